/* flist.f */
+incdir+hdl
hdl/pcie_glue_pkg.sv
hdl/ctl_init_writer.sv
hdl/mmio_responder.sv
hdl/dma_read_requester.sv
hdl/read_beat_log.sv
hdl/throughput_counter.sv
hdl/pcie_glue_top.sv
bench/tb_pcie_glue.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    := --binary --timing --timescale 1ns/1ps
TOP       := tb_pcie_glue
FLIST     := flist.f
OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(wildcard hdl/*.sv hdl/*.svh bench/*.sv)

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "NO ERRORS" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/tb_pcie_glue.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pcie_glue_consts.svh"

module tb_pcie_glue;
    import pcie_glue_pkg::*;

    localparam int TB_AR_PERIOD   = 16;
    // About ten times the summed length of the five tests
    localparam int TIMEOUT_CYCLES = 4000;

    logic        axi_clk = 1'b0;
    logic        axi_reset;
    lite_wr_t    o_ctl_aw;
    logic        o_ctl_awvalid, o_ctl_wvalid, i_ctl_awready, i_ctl_wready, o_ctl_bready;
    logic        i_m_arvalid, o_m_arready, o_m_rvalid, i_m_rready;
    axi_r_beat_t o_m_r;
    axi_aw_t     i_m_aw;
    axi_w_t      i_m_w;
    logic        i_m_awvalid, o_m_awready, i_m_wvalid, o_m_wready, o_m_bvalid, i_m_bready;
    logic        o_read_enable;
    axi_ar_t     o_s_ar;
    logic        o_s_arvalid, i_s_arready, i_s_rvalid, o_s_rready;
    axi_r_beat_t i_s_r;
    log_sel_t    i_log_sel;
    axi_r_beat_t o_log_entry;
    logic        i_second_tick;
    byte_count_t o_ar_bytes, o_r_bytes;
    rate_count_t o_ar_sec_bytes, o_r_sec_bytes;

    // Observed handshakes, filled by the monitor
    lite_wr_t    ctl_aw_q[$];
    lite_wr_t    ctl_w_q[$];
    axi_r_beat_t m_r_q[$];
    axi_ar_t     s_ar_q[$];
    int          ctl_hold_breaks = 0;
    int          s_ar_hold_breaks = 0;
    int          m_ar_fires = 0;
    int          m_aw_fires = 0;
    int          m_w_fires = 0;
    int          m_b_fires = 0;
    int          m_arready_busy = 0;
    int          s_r_beats = 0;
    logic        prev_ctl_awstall = 1'b0;
    logic        prev_ctl_wstall = 1'b0;
    logic        prev_s_arstall = 1'b0;
    lite_wr_t    prev_ctl_aw;
    axi_ar_t     prev_s_ar;
    rate_count_t ar_inc, r_inc;
    rate_count_t win_ar = '0;
    rate_count_t win_r = '0;
    rate_count_t sec_ar_exp = '0;
    rate_count_t sec_r_exp = '0;

    string       test_name = "reset";
    int          test_errors = 0;
    int          errors = 0;
    int          checks = 0;
    int          cycle_count = 0;

    pcie_glue_top #(
        .AR_PERIOD (TB_AR_PERIOD)
    ) dut0 (
        .i_axi_clk   (axi_clk),
        .i_axi_reset (axi_reset),
        .*
    );

    always #2 axi_clk = ~axi_clk;

    always @(posedge axi_clk) begin
        cycle_count++;
        if (cycle_count == TIMEOUT_CYCLES) begin
            $display("Timeout in %s after %0d cycles", test_name, cycle_count);
            $display("ERRORS FOUND");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////////
    // Monitor, samples mid-cycle when every signal has settled
    //////////////////////////////////////////////////////////////////////////

    always @(negedge axi_clk) begin
        if (!axi_reset) begin
            if (o_ctl_awvalid && i_ctl_awready)
                ctl_aw_q.push_back(o_ctl_aw);
            if (o_ctl_wvalid && i_ctl_wready)
                ctl_w_q.push_back(o_ctl_aw);
            if ((prev_ctl_awstall && !o_ctl_awvalid) || (prev_ctl_wstall && !o_ctl_wvalid)
                    || ((prev_ctl_awstall || prev_ctl_wstall) && o_ctl_aw != prev_ctl_aw))
                ctl_hold_breaks++;

            if (i_m_arvalid && o_m_arready)
                m_ar_fires++;
            if (o_m_rvalid && o_m_arready)
                m_arready_busy++;
            if (o_m_rvalid && i_m_rready)
                m_r_q.push_back(o_m_r);
            if (i_m_awvalid && o_m_awready)
                m_aw_fires++;
            if (i_m_wvalid && o_m_wready)
                m_w_fires++;
            if (o_m_bvalid && i_m_bready)
                m_b_fires++;

            if (o_s_arvalid && i_s_arready)
                s_ar_q.push_back(o_s_ar);
            if (prev_s_arstall && (!o_s_arvalid || o_s_ar != prev_s_ar))
                s_ar_hold_breaks++;
            if (i_s_rvalid && o_s_rready)
                s_r_beats++;

            // Byte window model, the tick cycle opens the next window
            ar_inc = (o_s_arvalid && i_s_arready) ? `PG_BURST_BYTES : 32'd0;
            r_inc  = (i_s_rvalid && o_s_rready) ? `PG_BEAT_BYTES : 32'd0;
            if (i_second_tick) begin
                sec_ar_exp = win_ar;
                sec_r_exp  = win_r;
                win_ar     = ar_inc;
                win_r      = r_inc;
            end else begin
                win_ar = win_ar + ar_inc;
                win_r  = win_r + r_inc;
            end
        end
        prev_ctl_awstall = o_ctl_awvalid && !i_ctl_awready;
        prev_ctl_wstall  = o_ctl_wvalid && !i_ctl_wready;
        prev_ctl_aw      = o_ctl_aw;
        prev_s_arstall   = o_s_arvalid && !i_s_arready;
        prev_s_ar        = o_s_ar;
    end

    //////////////////////////////////////////////////////////////////////////
    // Helpers and compare tasks
    //////////////////////////////////////////////////////////////////////////

    task automatic step_cycles(input int n);
        repeat (n) begin
            @(posedge axi_clk);
            #1;
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic end_test();
        $display("%-18s done, %0d failed checks", test_name, errors - test_errors);
    endtask

    task automatic expect_that(input logic ok, input string what);
        checks++;
        if (!ok) begin
            errors++;
            $display("%s: %s", test_name, what);
        end
    endtask

    task automatic check_addr(input string what, input axi_addr_t exp, input axi_addr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error: %s: %s expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_lite(input string what, input lite_wr_t exp, input lite_wr_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error: %s: %s expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_beat(input string what, input axi_r_beat_t exp,
                              input axi_r_beat_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error: %s: %s expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_bytes(input string what, input byte_count_t exp,
                               input byte_count_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error: %s: %s expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic check_rate(input string what, input rate_count_t exp,
                              input rate_count_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("** Error: %s: %s expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    // Single write on the master port, response taken after a short wait
    task automatic mmio_write(input axi_addr_t addr);
        int aw_base;
        int w_base;
        int b_base;
        aw_base       = m_aw_fires;
        w_base        = m_w_fires;
        b_base        = m_b_fires;
        i_m_aw.addr   = addr;
        i_m_aw.len    = 8'd0;
        i_m_w.data    = {$urandom, $urandom};
        i_m_w.strb    = '1;
        i_m_w.last    = 1'b1;
        i_m_awvalid   = 1'b1;
        i_m_wvalid    = 1'b1;
        while (m_aw_fires == aw_base)
            step_cycles(1);
        i_m_awvalid = 1'b0;
        i_m_wvalid  = 1'b0;
        expect_that(m_w_fires == w_base + 1,
                    "write data phase not accepted together with the address phase");
        step_cycles(2);
        expect_that(o_m_bvalid, "write response not held until bready");
        i_m_bready = 1'b1;
        step_cycles(3);
        i_m_bready = 1'b0;
        expect_that(m_b_fires == b_base + 1,
                    $sformatf("expected one write response, saw %0d", m_b_fires - b_base));
    endtask

    //////////////////////////////////////////////////////////////////////////
    // Tests
    //////////////////////////////////////////////////////////////////////////

    task automatic test_ctl_init();
        lite_wr_t exp_init [4];
        int       i;
        begin_test("test_ctl_init");
        exp_init[0] = '{addr: `PG_INIT_ADDR0, data: `PG_INIT_DATA0};
        exp_init[1] = '{addr: `PG_INIT_ADDR1, data: `PG_INIT_DATA1};
        exp_init[2] = '{addr: `PG_INIT_ADDR2, data: `PG_INIT_DATA2};
        exp_init[3] = '{addr: `PG_INIT_ADDR3, data: `PG_INIT_DATA3};
        while (ctl_aw_q.size() < 4 || ctl_w_q.size() < 4) begin
            i_ctl_awready = ($urandom % 3) == 0;
            i_ctl_wready  = ($urandom % 3) == 0;
            step_cycles(1);
        end
        // Keep ready moving so a fifth write would show up
        repeat (20) begin
            i_ctl_awready = ($urandom % 2) == 0;
            i_ctl_wready  = ($urandom % 2) == 0;
            step_cycles(1);
        end
        i_ctl_awready = 1'b0;
        i_ctl_wready  = 1'b0;
        expect_that(ctl_aw_q.size() == 4 && ctl_w_q.size() == 4,
                    $sformatf("expected four writes, saw %0d address and %0d data phases",
                              ctl_aw_q.size(), ctl_w_q.size()));
        for (i = 0; i < 4; i++) begin
            check_lite($sformatf("write %0d address phase", i), exp_init[i], ctl_aw_q[i]);
            check_lite($sformatf("write %0d data phase", i), exp_init[i], ctl_w_q[i]);
        end
        expect_that(!o_ctl_awvalid && !o_ctl_wvalid, "control valids high after the last write");
        expect_that(ctl_hold_breaks == 0, "control valid or payload changed under back-pressure");
        expect_that(o_ctl_bready, "control write responses are not accepted");
        end_test();
    endtask

    task automatic test_mmio();
        int          ar_base;
        int          r_base;
        logic        en_start;
        axi_r_beat_t exp_beat;
        begin_test("test_mmio");
        exp_beat.data = `PG_RD_FILL;
        exp_beat.id   = '0;
        exp_beat.last = 1'b1;
        exp_beat.resp = 2'b00;
        ar_base       = m_ar_fires;
        r_base        = m_r_q.size();
        i_m_arvalid   = 1'b1;
        while (m_ar_fires == ar_base)
            step_cycles(1);
        // Address stays valid while the beat is held back
        step_cycles(3);
        expect_that(o_m_rvalid, "read data valid did not rise after the address handshake");
        expect_that(m_ar_fires == ar_base + 1 && m_arready_busy == 0,
                    "read address accepted while a read beat was pending");
        i_m_arvalid = 1'b0;
        i_m_rready  = 1'b1;
        while (m_r_q.size() == r_base)
            step_cycles(1);
        i_m_rready = 1'b0;
        check_beat("read beat", exp_beat, m_r_q[r_base]);

        en_start = o_read_enable;
        expect_that(!en_start, "read enable not low after reset");
        mmio_write(`PG_TOGGLE_ADDR);
        expect_that(o_read_enable != en_start, "toggle address write did not flip read enable");
        mmio_write(32'h0000_1000);
        expect_that(o_read_enable != en_start, "write to another address changed read enable");
        mmio_write(`PG_TOGGLE_ADDR);
        expect_that(o_read_enable == en_start, "second toggle write did not restore read enable");
        end_test();
    endtask

    task automatic test_dma_requests();
        int   start_count;
        int   idle_count;
        logic raised;
        int   i;
        begin_test("test_dma_requests");
        start_count = s_ar_q.size();
        mmio_write(`PG_TOGGLE_ADDR);
        while (s_ar_q.size() < start_count + 5) begin
            i_s_arready = ($urandom % 4) == 0;
            step_cycles(1);
        end
        mmio_write(`PG_TOGGLE_ADDR);
        // A request raised just before the disable is still taken
        i_s_arready = 1'b1;
        step_cycles(3);
        idle_count = s_ar_q.size();
        raised     = 1'b0;
        repeat (3 * (TB_AR_PERIOD + 1)) begin
            raised = raised || o_s_arvalid;
            step_cycles(1);
        end
        i_s_arready = 1'b0;
        expect_that(!raised && s_ar_q.size() == idle_count, "request raised after disabling");
        expect_that(s_ar_hold_breaks == 0, "request valid or payload changed while stalled");
        for (i = 0; i < s_ar_q.size(); i++) begin
            check_addr($sformatf("request %0d address", i),
                       axi_addr_t'(i) * `PG_BURST_BYTES, s_ar_q[i].addr);
            expect_that(s_ar_q[i].len == `PG_BURST_LEN && s_ar_q[i].size == `PG_BURST_SIZE
                        && s_ar_q[i].burst == `PG_BURST_INCR,
                        $sformatf("request %0d has the wrong len, size or burst", i));
        end
        end_test();
    endtask

    task automatic test_beat_log();
        axi_r_beat_t sent [10];
        int          i;
        begin_test("test_beat_log");
        expect_that(o_s_rready, "read beats on the DMA port are not accepted");
        for (i = 0; i < 10; i++) begin
            sent[i].data = {$urandom, $urandom};
            sent[i].id   = axi_id_t'($urandom);
            sent[i].last = 1'($urandom);
            sent[i].resp = axi_resp_t'($urandom);
            i_s_r        = sent[i];
            i_s_rvalid   = 1'b1;
            step_cycles(1);
            i_s_rvalid = 1'b0;
            if (($urandom % 2) == 0)
                step_cycles(1);
        end
        step_cycles(1);
        for (i = 0; i < 8; i++) begin
            i_log_sel = log_sel_t'(i);
            step_cycles(1);
            check_beat($sformatf("log entry %0d", i), sent[9 - i], o_log_entry);
        end
        end_test();
    endtask

    task automatic test_throughput();
        int t;
        begin_test("test_throughput");
        mmio_write(`PG_TOGGLE_ADDR);
        for (t = 0; t < 140; t++) begin
            i_s_arready   = ($urandom % 2) == 0;
            i_s_rvalid    = ($urandom % 2) == 0;
            i_s_r.data    = {$urandom, $urandom};
            i_second_tick = (t == 30 || t == 100);
            if (t == 33 || t == 103) begin
                check_rate("requested bytes per second", sec_ar_exp, o_ar_sec_bytes);
                check_rate("received bytes per second", sec_r_exp, o_r_sec_bytes);
            end
            step_cycles(1);
        end
        i_second_tick = 1'b0;
        i_s_rvalid    = 1'b0;
        mmio_write(`PG_TOGGLE_ADDR);
        i_s_arready = 1'b1;
        step_cycles(3);
        i_s_arready = 1'b0;
        step_cycles(2);
        check_bytes("requested bytes", byte_count_t'(s_ar_q.size()) * 48'd2048, o_ar_bytes);
        check_bytes("received bytes", byte_count_t'(s_r_beats) * 48'd8, o_r_bytes);
        end_test();
    endtask

    initial begin
        void'($urandom(32'hd8541c9c));
        axi_reset     = 1'b1;
        i_ctl_awready = 1'b0;
        i_ctl_wready  = 1'b0;
        i_m_arvalid   = 1'b0;
        i_m_rready    = 1'b0;
        i_m_aw        = '0;
        i_m_awvalid   = 1'b0;
        i_m_w         = '0;
        i_m_wvalid    = 1'b0;
        i_m_bready    = 1'b0;
        i_s_arready   = 1'b0;
        i_s_r         = '0;
        i_s_rvalid    = 1'b0;
        i_log_sel     = '0;
        i_second_tick = 1'b0;
        repeat (2) @(posedge axi_clk);
        #1;
        axi_reset = 1'b0;

        test_ctl_init();
        test_mmio();
        test_dma_requests();
        test_beat_log();
        test_throughput();

        $display("Checks run: %0d, failed: %0d", checks, errors);
        if (errors == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* hdl/pcie_glue_top.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pcie_glue_consts.svh"

module pcie_glue_top #(
    parameter int unsigned AR_PERIOD = `PG_AR_PERIOD
) (
    input  wire                             i_axi_clk,
    input  wire                             i_axi_reset,
    // Control port
    output pcie_glue_pkg::lite_wr_t         o_ctl_aw,
    output logic                            o_ctl_awvalid,
    output logic                            o_ctl_wvalid,
    input  wire                             i_ctl_awready,
    input  wire                             i_ctl_wready,
    output logic                            o_ctl_bready,
    // Master port
    input  wire                             i_m_arvalid,
    output logic                            o_m_arready,
    output logic                            o_m_rvalid,
    input  wire                             i_m_rready,
    output pcie_glue_pkg::axi_r_beat_t      o_m_r,
    input  wire pcie_glue_pkg::axi_aw_t     i_m_aw,
    input  wire                             i_m_awvalid,
    output logic                            o_m_awready,
    input  wire pcie_glue_pkg::axi_w_t      i_m_w,
    input  wire                             i_m_wvalid,
    output logic                            o_m_wready,
    output logic                            o_m_bvalid,
    input  wire                             i_m_bready,
    output logic                            o_read_enable,
    // DMA port
    output pcie_glue_pkg::axi_ar_t          o_s_ar,
    output logic                            o_s_arvalid,
    input  wire                             i_s_arready,
    input  wire pcie_glue_pkg::axi_r_beat_t i_s_r,
    input  wire                             i_s_rvalid,
    output logic                            o_s_rready,
    // Read beat log
    input  wire pcie_glue_pkg::log_sel_t    i_log_sel,
    output pcie_glue_pkg::axi_r_beat_t      o_log_entry,
    // Throughput
    input  wire                             i_second_tick,
    output pcie_glue_pkg::byte_count_t      o_ar_bytes,
    output pcie_glue_pkg::byte_count_t      o_r_bytes,
    output pcie_glue_pkg::rate_count_t      o_ar_sec_bytes,
    output pcie_glue_pkg::rate_count_t      o_r_sec_bytes
);

    logic ar_fire;
    logic r_fire;

    // Responses and read data are never back-pressured
    assign o_ctl_bready = 1'b1;
    assign o_s_rready   = 1'b1;

    assign ar_fire = o_s_arvalid && i_s_arready;
    assign r_fire  = i_s_rvalid && o_s_rready;

    ////////////////////////////////////////////////////////////////////////////
    // Control port setup and master-port responder
    ////////////////////////////////////////////////////////////////////////////

    ctl_init_writer u_ctl_init (
        .i_axi_clk     (i_axi_clk),
        .i_axi_reset   (i_axi_reset),
        .o_ctl_aw      (o_ctl_aw),
        .o_ctl_awvalid (o_ctl_awvalid),
        .o_ctl_wvalid  (o_ctl_wvalid),
        .i_ctl_awready (i_ctl_awready),
        .i_ctl_wready  (i_ctl_wready)
    );

    mmio_responder u_mmio (
        .i_axi_clk     (i_axi_clk),
        .i_axi_reset   (i_axi_reset),
        .i_m_arvalid   (i_m_arvalid),
        .o_m_arready   (o_m_arready),
        .o_m_rvalid    (o_m_rvalid),
        .i_m_rready    (i_m_rready),
        .o_m_r         (o_m_r),
        .i_m_aw        (i_m_aw),
        .i_m_awvalid   (i_m_awvalid),
        .o_m_awready   (o_m_awready),
        .i_m_w         (i_m_w),
        .i_m_wvalid    (i_m_wvalid),
        .o_m_wready    (o_m_wready),
        .o_m_bvalid    (o_m_bvalid),
        .i_m_bready    (i_m_bready),
        .o_read_enable (o_read_enable)
    );

    ////////////////////////////////////////////////////////////////////////////
    // DMA reads, beat history and bandwidth
    ////////////////////////////////////////////////////////////////////////////

    dma_read_requester #(
        .AR_PERIOD (AR_PERIOD)
    ) u_dma_rd (
        .i_axi_clk     (i_axi_clk),
        .i_axi_reset   (i_axi_reset),
        .i_read_enable (o_read_enable),
        .o_s_ar        (o_s_ar),
        .o_s_arvalid   (o_s_arvalid),
        .i_s_arready   (i_s_arready)
    );

    read_beat_log u_beat_log (
        .i_axi_clk   (i_axi_clk),
        .i_axi_reset (i_axi_reset),
        .i_s_r       (i_s_r),
        .i_s_rvalid  (i_s_rvalid),
        .i_log_sel   (i_log_sel),
        .o_log_entry (o_log_entry)
    );

    throughput_counter u_tput (
        .i_axi_clk      (i_axi_clk),
        .i_axi_reset    (i_axi_reset),
        .i_ar_fire      (ar_fire),
        .i_r_fire       (r_fire),
        .i_second_tick  (i_second_tick),
        .o_ar_bytes     (o_ar_bytes),
        .o_r_bytes      (o_r_bytes),
        .o_ar_sec_bytes (o_ar_sec_bytes),
        .o_r_sec_bytes  (o_r_sec_bytes)
    );

endmodule

`default_nettype wire

/* hdl/throughput_counter.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pcie_glue_consts.svh"

module throughput_counter (
    input  wire                        i_axi_clk,
    input  wire                        i_axi_reset,
    input  wire                        i_ar_fire,
    input  wire                        i_r_fire,
    input  wire                        i_second_tick,
    output pcie_glue_pkg::byte_count_t o_ar_bytes,
    output pcie_glue_pkg::byte_count_t o_r_bytes,
    output pcie_glue_pkg::rate_count_t o_ar_sec_bytes,
    output pcie_glue_pkg::rate_count_t o_r_sec_bytes
);
    import pcie_glue_pkg::*;

    rate_count_t ar_inc;
    rate_count_t r_inc;
    rate_count_t ar_acc;
    rate_count_t r_acc;

    // Requested bytes per AR, received bytes per R beat
    assign ar_inc = i_ar_fire ? `PG_BURST_BYTES : '0;
    assign r_inc  = i_r_fire  ? `PG_BEAT_BYTES  : '0;

    always_ff @(posedge i_axi_clk) begin
        if (i_axi_reset) begin
            o_ar_bytes     <= '0;
            o_r_bytes      <= '0;
            ar_acc         <= '0;
            r_acc          <= '0;
            o_ar_sec_bytes <= '0;
            o_r_sec_bytes  <= '0;
        end else begin
            o_ar_bytes <= o_ar_bytes + byte_count_t'(ar_inc);
            o_r_bytes  <= o_r_bytes + byte_count_t'(r_inc);

            // Tick cycle opens the next window
            if (i_second_tick) begin
                o_ar_sec_bytes <= ar_acc;
                o_r_sec_bytes  <= r_acc;
                ar_acc         <= ar_inc;
                r_acc          <= r_inc;
            end else begin
                ar_acc <= ar_acc + ar_inc;
                r_acc  <= r_acc + r_inc;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/read_beat_log.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pcie_glue_consts.svh"

module read_beat_log (
    input  wire                             i_axi_clk,
    input  wire                             i_axi_reset,
    input  wire pcie_glue_pkg::axi_r_beat_t i_s_r,
    input  wire                             i_s_rvalid,
    input  wire pcie_glue_pkg::log_sel_t    i_log_sel,
    output pcie_glue_pkg::axi_r_beat_t      o_log_entry
);
    import pcie_glue_pkg::*;

    // Entry 0 holds the newest beat
    axi_r_beat_t log_q [`PG_LOG_DEPTH];

    always_ff @(posedge i_axi_clk) begin
        if (i_axi_reset) begin
            for (int i = 0; i < `PG_LOG_DEPTH; i++) begin
                log_q[i] <= '0;
            end
        end else if (i_s_rvalid) begin
            for (int i = `PG_LOG_DEPTH - 1; i > 0; i--) begin
                log_q[i] <= log_q[i-1];
            end
            log_q[0] <= i_s_r;
        end
    end

    // Read-out for inspection
    assign o_log_entry = log_q[i_log_sel];

endmodule

`default_nettype wire

/* hdl/dma_read_requester.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pcie_glue_consts.svh"

module dma_read_requester #(
    parameter int unsigned AR_PERIOD = `PG_AR_PERIOD
) (
    input  wire                    i_axi_clk,
    input  wire                    i_axi_reset,
    input  wire                    i_read_enable,
    output pcie_glue_pkg::axi_ar_t o_s_ar,
    output logic                   o_s_arvalid,
    input  wire                    i_s_arready
);
    import pcie_glue_pkg::*;

    logic [31:0] period_cnt;
    axi_addr_t   ar_addr;

    // Fixed burst shape, 256 beats of 64 bits
    assign o_s_ar = '{
        addr:   ar_addr,
        len:    `PG_BURST_LEN,
        size:   `PG_BURST_SIZE,
        burst:  `PG_BURST_INCR,
        id:     '0,
        region: '0
    };

    always_ff @(posedge i_axi_clk) begin
        if (i_axi_reset) begin
            period_cnt  <= 32'(AR_PERIOD);
            ar_addr     <= '0;
            o_s_arvalid <= 1'b0;
        end else begin
            if (period_cnt == '0) begin
                period_cnt <= 32'(AR_PERIOD);
            end else begin
                period_cnt <= period_cnt - 32'd1;
            end

            // Walk host memory one 2 KiB burst at a time
            if (o_s_arvalid && i_s_arready) begin
                ar_addr <= ar_addr + `PG_BURST_BYTES;
            end

            // Raise on the period boundary, hold until accepted
            if (period_cnt == '0 && i_read_enable) begin
                o_s_arvalid <= 1'b1;
            end else if (o_s_arvalid && i_s_arready) begin
                o_s_arvalid <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/mmio_responder.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pcie_glue_consts.svh"

module mmio_responder (
    input  wire                        i_axi_clk,
    input  wire                        i_axi_reset,
    // Read address and data
    input  wire                        i_m_arvalid,
    output logic                       o_m_arready,
    output logic                       o_m_rvalid,
    input  wire                        i_m_rready,
    output pcie_glue_pkg::axi_r_beat_t o_m_r,
    // Write address, data and response
    input  wire pcie_glue_pkg::axi_aw_t i_m_aw,
    input  wire                        i_m_awvalid,
    output logic                       o_m_awready,
    input  wire pcie_glue_pkg::axi_w_t i_m_w,
    input  wire                        i_m_wvalid,
    output logic                       o_m_wready,
    output logic                       o_m_bvalid,
    input  wire                        i_m_bready,
    output logic                       o_read_enable
);
    import pcie_glue_pkg::*;

    localparam axi_resp_t RESP_OKAY = 2'b00;

    logic wr_fire;

    // Single outstanding read, new address only once the beat is taken
    assign o_m_arready = !o_m_rvalid;
    assign o_m_r       = '{data: `PG_RD_FILL, id: '0, last: 1'b1, resp: RESP_OKAY};

    // AW and W are taken together, and only with no response pending
    assign o_m_awready = !o_m_bvalid && i_m_awvalid && i_m_wvalid;
    assign o_m_wready  = o_m_awready;
    assign wr_fire     = o_m_awready;

    always_ff @(posedge i_axi_clk) begin
        if (i_axi_reset) begin
            o_m_rvalid    <= 1'b0;
            o_m_bvalid    <= 1'b0;
            o_read_enable <= 1'b0;
        end else begin
            if (o_m_rvalid && i_m_rready) begin
                o_m_rvalid <= 1'b0;
            end else if (i_m_arvalid && o_m_arready) begin
                o_m_rvalid <= 1'b1;
            end

            if (o_m_bvalid && i_m_bready) begin
                o_m_bvalid <= 1'b0;
            end else if (wr_fire) begin
                o_m_bvalid <= 1'b1;
            end

            // Magic write flips DMA enable
            if (wr_fire && i_m_aw.addr == `PG_TOGGLE_ADDR) begin
                o_read_enable <= !o_read_enable;
            end
        end
    end

endmodule

`default_nettype wire

/* hdl/ctl_init_writer.sv */
`timescale 1ns/1ps
`default_nettype none

`include "pcie_glue_consts.svh"

module ctl_init_writer (
    input  wire                     i_axi_clk,
    input  wire                     i_axi_reset,
    output pcie_glue_pkg::lite_wr_t o_ctl_aw,
    output logic                    o_ctl_awvalid,
    output logic                    o_ctl_wvalid,
    input  wire                     i_ctl_awready,
    input  wire                     i_ctl_wready
);
    import pcie_glue_pkg::*;

    init_state_t state;
    logic [1:0]  wr_idx;
    lite_wr_t    next_wr;

    // Translation register table
    always_comb begin
        case (wr_idx)
            2'd0:    next_wr = '{addr: `PG_INIT_ADDR0, data: `PG_INIT_DATA0};
            2'd1:    next_wr = '{addr: `PG_INIT_ADDR1, data: `PG_INIT_DATA1};
            2'd2:    next_wr = '{addr: `PG_INIT_ADDR2, data: `PG_INIT_DATA2};
            default: next_wr = '{addr: `PG_INIT_ADDR3, data: `PG_INIT_DATA3};
        endcase
    end

    always_ff @(posedge i_axi_clk) begin
        if (i_axi_reset) begin
            state         <= INIT_ISSUE;
            wr_idx        <= '0;
            o_ctl_awvalid <= 1'b0;
            o_ctl_wvalid  <= 1'b0;
        end else begin
            case (state)
                INIT_ISSUE: begin
                    o_ctl_awvalid <= 1'b1;
                    o_ctl_wvalid  <= 1'b1;
                    state         <= INIT_WAIT;
                end
                INIT_WAIT: begin
                    // Address and data phases may complete in either order
                    o_ctl_awvalid <= o_ctl_awvalid && !i_ctl_awready;
                    o_ctl_wvalid  <= o_ctl_wvalid && !i_ctl_wready;
                    if (!o_ctl_awvalid && !o_ctl_wvalid) begin
                        if (wr_idx == 2'(`PG_INIT_WRITES - 1)) begin
                            state <= INIT_DONE;
                        end else begin
                            wr_idx <= wr_idx + 2'd1;
                            state  <= INIT_ISSUE;
                        end
                    end
                end
                default: begin
                    o_ctl_awvalid <= 1'b0;
                    o_ctl_wvalid  <= 1'b0;
                end
            endcase
        end
    end

    // Payload loads with the valids and holds under back-pressure
    always_ff @(posedge i_axi_clk) begin
        if (state == INIT_ISSUE) begin
            o_ctl_aw <= next_wr;
        end
    end

endmodule

`default_nettype wire

/* hdl/pcie_glue_pkg.sv */
`default_nettype none

`include "pcie_glue_consts.svh"

package pcie_glue_pkg;

    typedef logic [`PG_AXI_ADDR_W-1:0]  axi_addr_t;
    typedef logic [`PG_AXI_DATA_W-1:0]  axi_data_t;
    typedef logic [`PG_LITE_DATA_W-1:0] lite_data_t;
    typedef logic [`PG_ID_W-1:0]        axi_id_t;
    typedef logic [1:0]                 axi_resp_t;

    // Throughput counts
    typedef logic [47:0] byte_count_t;
    typedef logic [31:0] rate_count_t;

    typedef logic [$clog2(`PG_LOG_DEPTH)-1:0] log_sel_t;

    // Read request, DMA port
    typedef struct packed {
        axi_addr_t  addr;
        logic [7:0] len;
        logic [2:0] size;
        logic [1:0] burst;
        axi_id_t    id;
        logic [3:0] region;
    } axi_ar_t;

    typedef struct packed {
        axi_data_t data;
        axi_id_t   id;
        logic      last;
        axi_resp_t resp;
    } axi_r_beat_t;

    // Only address and length are looked at on the master port
    typedef struct packed {
        axi_addr_t  addr;
        logic [7:0] len;
    } axi_aw_t;

    typedef struct packed {
        axi_data_t                  data;
        logic [`PG_AXI_DATA_W/8-1:0] strb;
        logic                       last;
    } axi_w_t;

    // Control-port write, address and data phases share one payload
    typedef struct packed {
        axi_addr_t  addr;
        lite_data_t data;
    } lite_wr_t;

    typedef enum logic [1:0] {
        INIT_ISSUE,
        INIT_WAIT,
        INIT_DONE
    } init_state_t;

endpackage

`default_nettype wire

/* hdl/pcie_glue_consts.svh */
`ifndef PCIE_GLUE_CONSTS_SVH
`define PCIE_GLUE_CONSTS_SVH

// Bus widths
`define PG_AXI_ADDR_W   32
`define PG_AXI_DATA_W   64
`define PG_LITE_DATA_W  32
`define PG_ID_W         4

// DMA read burst, 256 beats of 8 bytes
`define PG_BURST_LEN    8'd255
`define PG_BURST_SIZE   3'd3
`define PG_BURST_INCR   2'd1
`define PG_BURST_BYTES  32'd2048
`define PG_BEAT_BYTES   32'd8

// Default cycles between DMA requests
`define PG_AR_PERIOD    32'h0000_A000

// Master-port responder
`define PG_TOGGLE_ADDR  32'h0000_CCCC
`define PG_RD_FILL      64'h0000_1234_5678_0000

`define PG_LOG_DEPTH    8

// AXIBAR2PCIEBAR translation setup on the control port
`define PG_INIT_WRITES  4
`define PG_INIT_ADDR0   32'h0000_1208
`define PG_INIT_DATA0   32'h0000_0010
`define PG_INIT_ADDR1   32'h0000_120C
`define PG_INIT_DATA1   32'h0000_0000
`define PG_INIT_ADDR2   32'h0000_1210
`define PG_INIT_DATA2   32'h0000_0010
`define PG_INIT_ADDR3   32'h0000_1214
`define PG_INIT_DATA3   32'h8000_0000

`endif
